// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= otp_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
verilog/otp_pkg.sv
verilog/otp_cmd_if.sv
verilog/otp_macro_if.sv
verilog/otp_resp_if.sv
verilog/otp_cmd_intake.sv
verilog/otp_sequencer.sv
verilog/otp_array.sv
verilog/otp_resp_collect.sv
verilog/otp_top.sv
verification/otp_tb.sv

// ==== verification/otp_tb.sv ====
////////////////////
// OTP macro emulation testbench
// LFSR commands checked against a codeword model
////////////////////
module otp_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import otp_pkg::*;

  localparam int ClkPeriod = 20;
  // Commands issued by all tests
  localparam int NumCmds = 130;
  localparam int WatchdogCycles = (NumCmds + 2) * 40;
  localparam int RespTimeout = 200;
  // Check bit j is the parity of the data bits in mask j
  localparam logic [15:0] CheckMasks [6] = '{
    16'h2CB7, 16'h555B, 16'h9A6D, 16'hE38E, 16'h03F0, 16'hFC00
  };

  logic      clk_i;
  logic      rst_ni;
  logic      valid_i;
  otp_cmd_e  cmd_i;
  otp_size_t size_i;
  otp_addr_t addr_i;
  otp_data_t wdata_i;
  logic      ready_o;
  logic      valid_o;
  otp_data_t rdata_o;
  otp_err_e  err_o;
  logic      fatal_alert_o;

  logic [31:0] lfsr_q;
  // Model codewords and allocation map
  otp_cw_t     mem_m [OtpDepth];
  bit          used_m [OtpDepth];
  otp_addr_t   rec_addr [40];
  otp_size_t   rec_size [40];
  int          errors;
  int          proto_errors;

  otp_top uut (
    .clk_i,
    .rst_ni,
    .valid_i,
    .cmd_i,
    .size_i,
    .addr_i,
    .wdata_i,
    .ready_o,
    .valid_o,
    .rdata_o,
    .err_o,
    .fatal_alert_o
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////
  // Random source
  ////////////////////
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h80200003 : 32'h0);
    end
    return r;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  function automatic otp_cw_t encode_word(input otp_word_t d);
    otp_cw_t cw;
    cw = {6'b0, d};
    for (int j = 0; j < 6; j++) begin
      cw[16+j] = ^(d & CheckMasks[j]);
    end
    return cw;
  endfunction

  // Zero syndrome clean, odd weight single, nonzero even weight double
  task automatic decode_word(input otp_cw_t cw, output otp_word_t d, output logic corr,
                             output logic uncorr);
    otp_cw_t    ref_cw;
    logic [5:0] syn;
    logic [5:0] col;
    ref_cw = encode_word(cw[15:0]);
    syn    = ref_cw[21:16] ^ cw[21:16];
    d      = cw[15:0];
    corr   = (syn != 6'd0) && (^syn);
    uncorr = (syn != 6'd0) && !(^syn);
    if (corr) begin
      for (int i = 0; i < 16; i++) begin
        for (int j = 0; j < 6; j++) begin
          col[j] = CheckMasks[j][i];
        end
        if (col == syn) d[i] = ~d[i];
      end
    end
  endtask

  // Expected response, updates the model array
  task automatic model_cmd(input otp_cmd_e c, input otp_addr_t a, input otp_size_t s,
                           input otp_data_t wd, output otp_data_t exp_d,
                           output otp_err_e exp_e, output int nchk);
    otp_addr_t wa;
    otp_cw_t   new_cw;
    otp_word_t w;
    logic      corr;
    logic      uncorr;
    bit        stop;
    exp_d = '0;
    exp_e = NoError;
    nchk  = 0;
    stop  = 1'b0;
    for (int k = 0; k <= int'(s); k++) begin
      wa = a + otp_addr_t'(k);
      w  = wd[16*k +: 16];
      case (c)
        Write, WriteRaw: begin
          new_cw = (c == Write) ? encode_word(w) : {6'b0, w};
          // Stored one that the new codeword lacks
          if ((mem_m[wa] & ~new_cw) != '0) exp_e = MacroWriteBlankError;
          mem_m[wa] = mem_m[wa] | new_cw;
        end
        Zeroize: begin
          mem_m[wa] = '1;
          exp_d[16*k +: 16] = 16'hFFFF;
          nchk = k + 1;
        end
        Read, ReadRaw: if (!stop) begin
          corr   = 1'b0;
          uncorr = 1'b0;
          w      = mem_m[wa][15:0];
          if (c == Read) decode_word(mem_m[wa], w, corr, uncorr);
          if (corr) exp_e = MacroEccCorrError;
          // Uncorrectable word ends the read
          if (uncorr) begin
            exp_e = MacroEccUncorrError;
            stop  = 1'b1;
          end
          exp_d[16*k +: 16] = w;
          nchk = k + 1;
        end
        default: ;
      endcase
    end
    if (stop) nchk = 0;
  endtask

  ////////////////////
  // Bus handling
  ////////////////////
  task automatic expect_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic send_cmd(input otp_cmd_e c, input otp_addr_t a, input otp_size_t s,
                          input otp_data_t wd);
    int n;
    n = 0;
    @(posedge clk_i);
    valid_i <= 1'b1;
    cmd_i   <= c;
    addr_i  <= a;
    size_i  <= s;
    wdata_i <= wd;
    // Held until ready_o, taken at the next edge
    do begin
      @(negedge clk_i);
      n++;
    end while (!ready_o && n < RespTimeout);
    if (!ready_o) begin
      $display("Error: command %s was never accepted", c.name());
      errors++;
    end
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  task automatic wait_resp(output otp_data_t d, output otp_err_e e, output bit seen);
    int n;
    n    = 0;
    seen = 1'b0;
    d    = '0;
    e    = NoError;
    while (!seen && n < RespTimeout) begin
      @(negedge clk_i);
      n++;
      if (fatal_alert_o !== 1'b0) begin
        $display("Error: fatal_alert_o raised during a command");
        proto_errors++;
      end
      if (valid_o === 1'b1) begin
        seen = 1'b1;
        d    = rdata_o;
        e    = err_o;
      end else if (ready_o !== 1'b0) begin
        // Busy from the cycle after the take
        $display("Fail ready_o: got %h expected 0 while busy", ready_o);
        proto_errors++;
      end
    end
    if (!seen) begin
      $display("Error: no valid_o within %0d cycles", RespTimeout);
      errors++;
    end
  endtask

  task automatic run_cmd(input otp_cmd_e c, input otp_addr_t a, input otp_size_t s,
                         input otp_data_t wd);
    otp_data_t exp_d;
    otp_data_t got_d;
    otp_err_e  exp_e;
    otp_err_e  got_e;
    int        nchk;
    bit        seen;
    model_cmd(c, a, s, wd, exp_d, exp_e, nchk);
    send_cmd(c, a, s, wd);
    wait_resp(got_d, got_e, seen);
    if (seen) begin
      expect_value($sformatf("err_o %s @%h", c.name(), a), 64'(got_e), 64'(exp_e));
      for (int k = 0; k < nchk; k++) begin
        expect_value($sformatf("rdata_o[%0d] %s @%h", k, c.name(), a),
                     64'(got_d[16*k +: 16]), 64'(exp_d[16*k +: 16]));
      end
    end
  endtask

  // Random range of s+1 unused words below the top
  task automatic pick_free(input otp_size_t s, output otp_addr_t a);
    bit ok;
    int tries;
    ok    = 1'b0;
    tries = 0;
    a     = '0;
    while (!ok && tries < 1000) begin
      a = otp_addr_t'(rand_bits(8));
      tries++;
      ok = (int'(a) + int'(s)) < OtpDepth;
      for (int k = 0; k <= int'(s); k++) begin
        if (ok && used_m[a + otp_addr_t'(k)]) ok = 1'b0;
      end
    end
    if (!ok) begin
      $display("Error: no free address range found");
      errors++;
    end
    for (int k = 0; k <= int'(s); k++) begin
      used_m[a + otp_addr_t'(k)] = 1'b1;
    end
  endtask

  // Random data bit still unprogrammed in the model
  task automatic pick_clear_bit(input otp_addr_t a, input int avoid, output int b);
    int tries;
    tries = 0;
    do begin
      b = int'(rand_bits(4));
      tries++;
    end while ((mem_m[a][b] || b == avoid) && tries < 100);
    if (mem_m[a][b] || b == avoid) begin
      $display("Error: no clear data bit found at %h", a);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int n);
    $display("Test %s: %0d errors", name, n);
  endtask

  ////////////////////
  // Tests
  ////////////////////
  initial begin : main
    otp_addr_t a;
    otp_size_t s;
    otp_data_t wd;
    int        b1;
    int        b2;
    int        mark;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    valid_i      = 1'b0;
    cmd_i        = Read;
    size_i       = '0;
    addr_i       = '0;
    wdata_i      = '0;
    lfsr_q       = 32'h03ff82ee;
    errors       = 0;
    proto_errors = 0;
    b2           = 0;
    for (int i = 0; i < OtpDepth; i++) begin
      mem_m[i]  = '0;
      used_m[i] = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset values, command before Init, Init
    mark = errors;
    @(negedge clk_i);
    expect_value("ready_o", 64'(ready_o), 64'd1);
    expect_value("valid_o", 64'(valid_o), 64'd0);
    expect_value("fatal_alert_o", 64'(fatal_alert_o), 64'd0);
    expect_value("rdata_o", rdata_o, 64'd0);
    expect_value("err_o", 64'(err_o), 64'(NoError));
    send_cmd(Read, '0, '0, '0);
    repeat (20) begin
      @(negedge clk_i);
      if (valid_o !== 1'b0) begin
        $display("Error: valid_o raised for a command before Init");
        errors++;
      end
    end
    run_cmd(Init, '0, '0, '0);
    report_test("reset_init", errors - mark);

    // ECC writes to blank words, read back
    mark = errors;
    for (int i = 0; i < 40; i++) begin
      s = otp_size_t'(rand_bits(2));
      pick_free(s, a);
      wd[63:32]   = rand_bits(32);
      wd[31:0]    = rand_bits(32);
      rec_addr[i] = a;
      rec_size[i] = s;
      run_cmd(Write, a, s, wd);
      run_cmd(Read, a, s, '0);
    end
    report_test("write_read", errors - mark);

    // Second program ORs in, blank check on cleared ones
    mark = errors;
    for (int i = 0; i < 8; i++) begin
      wd[63:32] = rand_bits(32);
      wd[31:0]  = rand_bits(32);
      run_cmd(Write, rec_addr[i], rec_size[i], wd);
      run_cmd(ReadRaw, rec_addr[i], rec_size[i], '0);
    end
    report_test("accumulate", errors - mark);

    // Raw bit flips on ECC words, single then double
    mark = errors;
    for (int i = 8; i < 20; i++) begin
      a = rec_addr[i];
      pick_clear_bit(a, -1, b1);
      wd = otp_data_t'(1) << b1;
      if (i >= 14) begin
        pick_clear_bit(a, b1, b2);
        wd = wd | (otp_data_t'(1) << b2);
      end
      run_cmd(WriteRaw, a, '0, wd);
      run_cmd(Read, a, '0, '0);
    end
    report_test("ecc_errors", errors - mark);

    mark = errors;
    for (int i = 0; i < 4; i++) begin
      s = otp_size_t'(rand_bits(2));
      pick_free(s, a);
      run_cmd(Zeroize, a, s, '0);
      run_cmd(ReadRaw, a, s, '0);
    end
    report_test("zeroize", errors - mark);

    // Alert and ready_o were watched during every command
    report_test("alert_ready", proto_errors);

    $display("Tests run 6, value errors %0d, protocol errors %0d", errors, proto_errors);
    if (errors == 0 && proto_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Ends a hung run
  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: run exceeded %0d cycles", WatchdogCycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== verilog/otp_array.sv ====
////////////////////
// Single-port codeword storage
// Registered request and read data, reads return after two cycles
////////////////////
module otp_array (
  input logic           clk_i,
  input logic           rst_ni,
  otp_macro_if.array_mp mac
);
  import otp_pkg::*;

  otp_cw_t   mem [OtpDepth];
  logic      req_q, write_q;
  otp_addr_t addr_q;
  otp_cw_t   wdata_q;
  otp_cw_t   rdata_q;
  logic      rvalid_q;

  ////////////////////
  // Request stage
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b0;
      write_q <= 1'b0;
    end else begin
      req_q   <= mac.req;
      write_q <= mac.write;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mac.req) begin
      addr_q  <= mac.addr;
      wdata_q <= mac.wdata;
    end
  end

  ////////////////////
  // Storage and read stage
  ////////////////////
  // Unprogrammed fuses read as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < OtpDepth; i++) begin
        mem[i] <= '0;
      end
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_q && !write_q;
      if (req_q && write_q) mem[addr_q] <= wdata_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_q && !write_q) rdata_q <= mem[addr_q];
  end

  assign mac.rdata  = rdata_q;
  assign mac.rvalid = rvalid_q;

  // Programming never clears a stored fuse
  no_clear_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_q && write_q |-> (wdata_q & mem[addr_q]) == mem[addr_q]);

endmodule

// ==== verilog/otp_cmd_if.sv ====
////////////////////
// Captured command from intake to sequencer
////////////////////
interface otp_cmd_if;
  import otp_pkg::*;

  // One-cycle launch strobe, fields hold until next capture
  logic      start;
  otp_op_e   op;
  logic      integrity_en;
  otp_addr_t addr;
  otp_size_t size;
  otp_data_t wdata;
  // Sequencer can take a new command
  logic      idle;

  modport intake_mp (output start, op, integrity_en, addr, size, wdata, input idle);
  modport seq_mp (input start, op, integrity_en, addr, size, wdata, output idle);

endinterface

// ==== verilog/otp_cmd_intake.sv ====
////////////////////
// Command intake
// Takes valid/ready commands and launches legal ones to the sequencer
////////////////////
module otp_cmd_intake (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               valid_i,
  input  otp_pkg::otp_cmd_e  cmd_i,
  input  otp_pkg::otp_size_t size_i,
  input  otp_pkg::otp_addr_t addr_i,
  input  otp_pkg::otp_data_t wdata_i,
  output logic               ready_o,
  otp_cmd_if.intake_mp       cmd
);
  import otp_pkg::*;

  logic    take;
  logic    legal;
  otp_op_e op_d;
  logic    integ_d;

  // No new take while a launch is still in flight
  assign ready_o = cmd.idle && !cmd.start;
  assign take    = valid_i && ready_o;

  // Map native code to operation and ECC mode
  always_comb begin
    legal   = 1'b1;
    op_d    = OpRead;
    integ_d = 1'b0;
    case (cmd_i)
      Init:     op_d = OpInit;
      Read:     integ_d = 1'b1;
      ReadRaw:  op_d = OpRead;
      Write: begin
        op_d    = OpWrite;
        integ_d = 1'b1;
      end
      WriteRaw: op_d = OpWrite;
      Zeroize:  op_d = OpZeroize;
      default:  legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd.start        <= 1'b0;
      cmd.op           <= OpInit;
      cmd.integrity_en <= 1'b0;
    end else begin
      // Illegal codes are swallowed here
      cmd.start <= take && legal;
      if (take && legal) begin
        cmd.op           <= op_d;
        cmd.integrity_en <= integ_d;
      end
    end
  end

  // Payload fields
  always_ff @(posedge clk_i) begin
    if (take) begin
      cmd.addr  <= addr_i;
      cmd.size  <= size_i;
      cmd.wdata <= wdata_i;
    end
  end

  // An illegal code launches nothing, so the intake stays ready
  illegal_not_started_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    take && !legal |=> ready_o);
  // Sequencer stays idle until it has seen the launch
  start_when_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd.start |-> cmd.idle);

endmodule

// ==== verilog/otp_macro_if.sv ====
////////////////////
// Request and read-return bus of the storage array
////////////////////
interface otp_macro_if;
  import otp_pkg::*;

  logic      req;
  logic      write;
  otp_addr_t addr;
  otp_cw_t   wdata;
  // Read return, two cycles after the request
  otp_cw_t   rdata;
  logic      rvalid;

  modport seq_mp (output req, write, addr, wdata, input rvalid);
  modport array_mp (input req, write, addr, wdata, output rdata, rvalid);
  modport mon_mp (input rdata, rvalid);

endinterface

// ==== verilog/otp_pkg.sv ====
////////////////////
// OTP macro emulation shared definitions
// Widths, command and error codes, SECDED (22,16) code
////////////////////
package otp_pkg;

  localparam int OtpWidth     = 16;
  localparam int OtpEccWidth  = 6;
  localparam int OtpCwWidth   = OtpWidth + OtpEccWidth;
  localparam int OtpDepth     = 256;
  localparam int OtpAddrWidth = 8;
  localparam int OtpSizeWidth = 2;
  localparam int OtpMaxWords  = 4;
  localparam int OtpIfWidth   = OtpMaxWords * OtpWidth;

  typedef logic [OtpWidth-1:0]     otp_word_t;
  // Data in 15..0, check bits in 21..16
  typedef logic [OtpCwWidth-1:0]   otp_cw_t;
  typedef logic [OtpAddrWidth-1:0] otp_addr_t;
  typedef logic [OtpSizeWidth-1:0] otp_size_t;
  typedef logic [OtpIfWidth-1:0]   otp_data_t;

  // Native macro command set, codes 6 and 7 are illegal
  typedef enum logic [2:0] {
    Read     = 3'b000,
    Write    = 3'b001,
    ReadRaw  = 3'b010,
    WriteRaw = 3'b011,
    Init     = 3'b100,
    Zeroize  = 3'b101
  } otp_cmd_e;

  typedef enum logic [1:0] {
    NoError              = 2'd0,
    MacroEccCorrError    = 2'd1,
    MacroEccUncorrError  = 2'd2,
    MacroWriteBlankError = 2'd3
  } otp_err_e;

  // Decoded operation, raw or ECC mode travels separately
  typedef enum logic [1:0] {
    OpInit,
    OpRead,
    OpWrite,
    OpZeroize
  } otp_op_e;

  // Every data column has weight 3 and all columns differ
  localparam logic [OtpEccWidth-1:0][OtpWidth-1:0] SecdedMasks = {
    16'hFC00, 16'h03F0, 16'hE38E, 16'h9A6D, 16'h555B, 16'h2CB7
  };

  function automatic otp_cw_t secded_encode(otp_word_t data);
    otp_cw_t cw;
    cw[OtpWidth-1:0] = data;
    for (int j = 0; j < OtpEccWidth; j++) begin
      cw[OtpWidth+j] = ^(data & SecdedMasks[j]);
    end
    return cw;
  endfunction

  // Recomputed parity against the stored check bits
  function automatic logic [OtpEccWidth-1:0] secded_syndrome(otp_cw_t cw);
    logic [OtpEccWidth-1:0] syn;
    for (int j = 0; j < OtpEccWidth; j++) begin
      syn[j] = ^(cw[OtpWidth-1:0] & SecdedMasks[j]) ^ cw[OtpWidth+j];
    end
    return syn;
  endfunction

endpackage

// ==== verilog/otp_resp_collect.sv ====
////////////////////
// Response collector
// SECDED decode of returned words and read data slots
////////////////////
module otp_resp_collect (
  input  logic               clk_i,
  input  logic               rst_ni,
  otp_macro_if.mon_mp        mac,
  otp_resp_if.coll_mp        rsp,
  output otp_pkg::otp_data_t rdata_o
);
  import otp_pkg::*;

  otp_cw_t                slot_q [OtpMaxWords];
  logic [OtpEccWidth-1:0] syn;
  logic                   syn_odd;
  otp_word_t              corr_word;

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin : p_decode
    logic [OtpEccWidth-1:0] col;
    syn       = secded_syndrome(mac.rdata);
    syn_odd   = ^syn;
    corr_word = mac.rdata[OtpWidth-1:0];
    // Flip the data bit whose column matches the syndrome
    for (int i = 0; i < OtpWidth; i++) begin
      for (int j = 0; j < OtpEccWidth; j++) begin
        col[j] = SecdedMasks[j][i];
      end
      if (syn == col) corr_word[i] = ~corr_word[i];
    end
  end

  // Odd weight is a single error, nonzero even weight a double
  assign rsp.corr_err   = mac.rvalid && rsp.ecc_on && syn_odd;
  assign rsp.uncorr_err = mac.rvalid && rsp.ecc_on && (syn != '0) && !syn_odd;

  // Slots past the command size keep old contents
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < OtpMaxWords; k++) begin
        slot_q[k] <= '0;
      end
    end else if (mac.rvalid) begin
      slot_q[rsp.idx] <= rsp.ecc_on ? {{OtpEccWidth{1'b0}}, corr_word} : mac.rdata;
    end
  end

  // Raw codeword for the read-modify-write
  assign rsp.stored_cw = slot_q[rsp.idx];

  always_comb begin
    for (int k = 0; k < OtpMaxWords; k++) begin
      rdata_o[k*OtpWidth +: OtpWidth] = slot_q[k][OtpWidth-1:0];
    end
  end

endmodule

// ==== verilog/otp_resp_if.sv ====
////////////////////
// Word slot, ECC mode and decode status between sequencer and collector
////////////////////
interface otp_resp_if;
  import otp_pkg::*;

  // Slot of the word in flight
  otp_size_t idx;
  logic      ecc_on;
  // Raw codeword held in slot idx
  otp_cw_t   stored_cw;
  logic      corr_err;
  logic      uncorr_err;

  modport seq_mp (output idx, ecc_on, input stored_cw, corr_err, uncorr_err);
  modport coll_mp (input idx, ecc_on, output stored_cw, corr_err, uncorr_err);

endinterface

// ==== verilog/otp_sequencer.sv ====
////////////////////
// Command sequencer
// Word loop, read-modify-write, blank check and error status
////////////////////
module otp_sequencer (
  input  logic              clk_i,
  input  logic              rst_ni,
  otp_cmd_if.seq_mp         cmd,
  otp_macro_if.seq_mp       mac,
  otp_resp_if.seq_mp        rsp,
  output logic              valid_o,
  output otp_pkg::otp_err_e err_o,
  output logic              fatal_alert_o
);
  import otp_pkg::*;

  typedef enum logic [3:0] {
    ResetSt, InitSt, IdleSt, ReadSt, ReadWaitSt, WriteCheckSt,
    WriteWaitSt, WriteSt, ZerWriteSt, ZerReadSt, ZerReadWaitSt, ErrorSt
  } state_e;

  state_e    state_d, state_q;
  otp_err_e  err_d, err_q;
  logic      valid_d, valid_q;
  otp_size_t cnt_d, cnt_q;
  logic      last, zer_en, blank_err;
  otp_word_t new_word;
  otp_cw_t   new_cw;

  assign last     = (cnt_q == cmd.size);
  assign cmd.idle = (state_q == ResetSt) || (state_q == IdleSt);
  assign rsp.idx  = cnt_q;
  assign mac.addr = cmd.addr + otp_addr_t'(cnt_q);
  assign valid_o  = valid_q;
  assign err_o    = err_q;

  ////////////////////
  // Read-modify-write
  ////////////////////
  assign new_word = cmd.wdata[OtpWidth*int'(cnt_q) +: OtpWidth];
  assign new_cw   = cmd.integrity_en ? secded_encode(new_word)
                                     : {{OtpEccWidth{1'b0}}, new_word};
  // Programming only sets bits, zeroize sets all of them
  assign mac.wdata = zer_en ? '1 : (rsp.stored_cw | new_cw);
  // A stored one that the new codeword would clear
  assign blank_err = (rsp.stored_cw & new_cw) != rsp.stored_cw;

  always_comb begin
    state_d = state_q;
    err_d = err_q;
    valid_d = 1'b0;
    cnt_d = cnt_q;
    mac.req = 1'b0;
    mac.write = 1'b0;
    rsp.ecc_on = 1'b0;
    zer_en = 1'b0;
    fatal_alert_o = 1'b0;
    unique case (state_q)
      // Only Init leaves reset, others are dropped
      ResetSt: if (cmd.start && cmd.op == OpInit) begin
        state_d = InitSt;
        valid_d = 1'b1;
      end
      InitSt: state_d = IdleSt;
      IdleSt: if (cmd.start) begin
        cnt_d = '0;
        err_d = NoError;
        case (cmd.op)
          OpRead:    state_d = ReadSt;
          OpWrite:   state_d = WriteCheckSt;
          OpZeroize: state_d = ZerWriteSt;
          default:   state_d = IdleSt;
        endcase
      end
      ReadSt: begin
        mac.req = 1'b1;
        rsp.ecc_on = cmd.integrity_en;
        state_d = ReadWaitSt;
      end
      ReadWaitSt: begin
        rsp.ecc_on = cmd.integrity_en;
        if (mac.rvalid) begin
          // Bail out on uncorrectable data
          if (rsp.uncorr_err) begin
            err_d = MacroEccUncorrError;
            valid_d = 1'b1;
            state_d = IdleSt;
          end else begin
            if (rsp.corr_err) err_d = MacroEccCorrError;
            if (last) begin
              valid_d = 1'b1;
              state_d = IdleSt;
            end else begin
              cnt_d = cnt_q + 1'b1;
              state_d = ReadSt;
            end
          end
        end
      end
      // Raw read-back of all words before programming
      WriteCheckSt: begin
        mac.req = 1'b1;
        state_d = WriteWaitSt;
      end
      WriteWaitSt: if (mac.rvalid) begin
        cnt_d = last ? '0 : cnt_q + 1'b1;
        state_d = last ? WriteSt : WriteCheckSt;
      end
      WriteSt: begin
        mac.req = 1'b1;
        mac.write = 1'b1;
        if (blank_err) err_d = MacroWriteBlankError;
        cnt_d = cnt_q + 1'b1;
        if (last) begin
          valid_d = 1'b1;
          state_d = IdleSt;
        end
      end
      ZerWriteSt: begin
        mac.req = 1'b1;
        mac.write = 1'b1;
        zer_en = 1'b1;
        cnt_d = last ? '0 : cnt_q + 1'b1;
        if (last) state_d = ZerReadSt;
      end
      ZerReadSt: begin
        mac.req = 1'b1;
        state_d = ZerReadWaitSt;
      end
      ZerReadWaitSt: if (mac.rvalid) begin
        cnt_d = cnt_q + 1'b1;
        valid_d = last;
        state_d = last ? IdleSt : ZerReadSt;
      end
      ErrorSt: fatal_alert_o = 1'b1;
      // Glitched state register
      default: begin
        state_d = ErrorSt;
        fatal_alert_o = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      err_q   <= NoError;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
      valid_q <= valid_d;
      cnt_q   <= cnt_d;
    end
  end

  no_wrap_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mac.req |-> mac.addr >= cmd.addr);
  // Read data only comes back while a wait state expects it
  rvalid_in_wait_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mac.rvalid |-> state_q inside {ReadWaitSt, WriteWaitSt, ZerReadWaitSt});

endmodule

// ==== verilog/otp_top.sv ====
////////////////////
// OTP macro emulation top level
////////////////////
module otp_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               valid_i,
  input  otp_pkg::otp_cmd_e  cmd_i,
  input  otp_pkg::otp_size_t size_i,
  input  otp_pkg::otp_addr_t addr_i,
  input  otp_pkg::otp_data_t wdata_i,
  output logic               ready_o,
  output logic               valid_o,
  output otp_pkg::otp_data_t rdata_o,
  output otp_pkg::otp_err_e  err_o,
  output logic               fatal_alert_o
);

  otp_cmd_if   cmd_if ();
  otp_macro_if mac_if ();
  otp_resp_if  rsp_if ();

  // Input side
  otp_cmd_intake u_intake (
    .clk_i,
    .rst_ni,
    .valid_i,
    .cmd_i,
    .size_i,
    .addr_i,
    .wdata_i,
    .ready_o,
    .cmd     (cmd_if.intake_mp)
  );

  otp_sequencer u_seq (
    .clk_i,
    .rst_ni,
    .cmd           (cmd_if.seq_mp),
    .mac           (mac_if.seq_mp),
    .rsp           (rsp_if.seq_mp),
    .valid_o,
    .err_o,
    .fatal_alert_o
  );

  otp_array u_array (
    .clk_i,
    .rst_ni,
    .mac    (mac_if.array_mp)
  );

  // Output side
  otp_resp_collect u_collect (
    .clk_i,
    .rst_ni,
    .mac     (mac_if.mon_mp),
    .rsp     (rsp_if.coll_mp),
    .rdata_o
  );

endmodule
